//--- hw/ow_axil_regs.sv
`timescale 1ns/1ps

module ow_axil_regs (
    input  logic                   clk,
    input  logic                   reset_flag,
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [1:0]             rresp,
    output ow_regs_pkg::ow_cmd_t   cmd,
    output logic                   cmd_valid,
    input  ow_regs_pkg::ow_status_t status
);

    ow_regs_pkg::ow_cmd_t last_cmd;
    ow_regs_pkg::ow_cmd_t wr_cmd;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 ctrl_ok;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign wr_cmd  = ow_regs_pkg::ow_cmd_t'(wdata[9:0]);

    // A CONTROL write goes through only while the sequencer is idle.
    assign ctrl_ok   = (awaddr == ow_regs_pkg::ADDR_CONTROL) && !status.busy;
    assign cmd_valid = wr_fire && ctrl_ok && (wr_cmd.op != ow_regs_pkg::OP_NONE);
    assign cmd       = wr_cmd;

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            last_cmd <= '0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (ctrl_ok) begin
                    last_cmd <= wr_cmd;
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= ctrl_ok ? ow_regs_pkg::RESP_OKAY : ow_regs_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr)
                ow_regs_pkg::ADDR_CONTROL: begin
                    rdata <= {22'd0, last_cmd};
                    rresp <= ow_regs_pkg::RESP_OKAY;
                end
                ow_regs_pkg::ADDR_STATUS: begin
                    rdata <= {22'd0, status}; // Snapshot taken at the address handshake.
                    rresp <= ow_regs_pkg::RESP_OKAY;
                end
                default: begin
                    rdata <= 32'd0;
                    rresp <= ow_regs_pkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

//--- hw/ow_bus_pkg.sv
package ow_bus_pkg;

    // Kinds of slot that the slot timer can put on the bus.
    typedef enum logic [1:0] {
        SLOT_RESET  = 2'd0,
        SLOT_WRITE0 = 2'd1,
        SLOT_WRITE1 = 2'd2,
        SLOT_READ   = 2'd3
    } slot_kind_e;

    // Request from the byte sequencer to the slot timer.
    typedef struct packed {
        logic       valid;
        slot_kind_e kind;
    } slot_req_t;

    // Result of one slot.
    typedef struct packed {
        logic done;    // One cycle pulse at the end of the slot.
        logic sampled; // Presence after a reset slot, data bit after a read slot.
    } slot_rsp_t;

endpackage

//--- hw/ow_byte_sequencer.sv
`timescale 1ns/1ps

module ow_byte_sequencer (
    input  logic                    clk,
    input  logic                    reset_flag,
    input  ow_regs_pkg::ow_cmd_t    cmd,
    input  logic                    cmd_valid,
    input  logic                    slot_ready,
    input  ow_bus_pkg::slot_rsp_t   slot_rsp,
    output ow_bus_pkg::slot_req_t   slot_req,
    output ow_regs_pkg::ow_status_t status
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT
    } state_e;

    state_e                 state;
    ow_regs_pkg::ow_op_e    op_q;
    ow_bus_pkg::slot_kind_e req_kind;
    logic                   req_valid;
    logic [7:0]             shreg;
    logic [7:0]             shreg_next;
    logic [2:0]             bit_cnt;
    logic                   busy;
    logic                   presence;
    logic [7:0]             rx_byte;

    function automatic ow_bus_pkg::slot_kind_e pick_kind(input ow_regs_pkg::ow_op_e op,
                                                        input logic lsb);
        ow_bus_pkg::slot_kind_e kind;
        case (op)
            ow_regs_pkg::OP_RESET:     kind = ow_bus_pkg::SLOT_RESET;
            ow_regs_pkg::OP_READ_BYTE: kind = ow_bus_pkg::SLOT_READ;
            default:                   kind = lsb ? ow_bus_pkg::SLOT_WRITE1
                                                  : ow_bus_pkg::SLOT_WRITE0;
        endcase
        return kind;
    endfunction

    // Reads shift the sampled bit in at the top, writes shift in zero.
    assign shreg_next = {(op_q == ow_regs_pkg::OP_READ_BYTE) && slot_rsp.sampled, shreg[7:1]};

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            state     <= S_IDLE;
            busy      <= 1'b0;
            req_valid <= 1'b0;
            presence  <= 1'b0;
            rx_byte   <= 8'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        busy      <= 1'b1;
                        op_q      <= cmd.op;
                        shreg     <= cmd.data;
                        bit_cnt   <= 3'd0;
                        req_kind  <= pick_kind(cmd.op, cmd.data[0]);
                        req_valid <= 1'b1;
                        state     <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (slot_ready) begin
                        req_valid <= 1'b0;
                        state     <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (slot_rsp.done) begin
                        if (op_q == ow_regs_pkg::OP_RESET) begin
                            presence <= slot_rsp.sampled;
                            busy     <= 1'b0;
                            state    <= S_IDLE;
                        end else begin
                            shreg <= shreg_next;
                            if (bit_cnt == 3'd7) begin
                                if (op_q == ow_regs_pkg::OP_READ_BYTE) begin
                                    rx_byte <= shreg_next;
                                end
                                busy  <= 1'b0;
                                state <= S_IDLE;
                            end else begin
                                bit_cnt   <= bit_cnt + 3'd1;
                                req_kind  <= pick_kind(op_q, shreg_next[0]);
                                req_valid <= 1'b1;
                                state     <= S_REQ;
                            end
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign slot_req = '{valid: req_valid, kind: req_kind};
    assign status   = '{busy: busy, presence: presence, rx_byte: rx_byte};

endmodule

//--- hw/ow_config.svh
`ifndef OW_CONFIG_SVH
`define OW_CONFIG_SVH

// System clock cycles in one microsecond.
`define OW_CLKS_PER_US 50

// Reset and presence detect.
`define OW_RESET_LOW_US 480
`define OW_PRESENCE_SAMPLE_US 70
`define OW_RESET_RECOVER_US 410

// Bit slots.
`define OW_SLOT_US 70
`define OW_WRITE1_LOW_US 6
`define OW_WRITE0_LOW_US 60
`define OW_READ_LOW_US 6
`define OW_READ_SAMPLE_US 15

`endif

//--- hw/ow_master_top.sv
`timescale 1ns/1ps

module ow_master_top (
    input  logic        clk,
    input  logic        reset_flag,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    input  logic        rready,
    output logic [1:0]  rresp,
    input  logic        ow_in,
    output logic        ow_pull_low
);

    ow_regs_pkg::ow_cmd_t    cmd;
    logic                    cmd_valid;
    ow_regs_pkg::ow_status_t status;
    ow_bus_pkg::slot_req_t   slot_req;
    ow_bus_pkg::slot_rsp_t   slot_rsp;
    logic                    slot_ready;

    ow_axil_regs regs_i (
        .clk        (clk),
        .reset_flag (reset_flag),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .rresp      (rresp),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .status     (status)
    );

    ow_byte_sequencer seq_i (
        .clk        (clk),
        .reset_flag (reset_flag),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .slot_ready (slot_ready),
        .slot_rsp   (slot_rsp),
        .slot_req   (slot_req),
        .status     (status)
    );

    ow_slot_timer timer_i (
        .clk         (clk),
        .reset_flag  (reset_flag),
        .slot_req    (slot_req),
        .ow_in       (ow_in),
        .slot_ready  (slot_ready),
        .slot_rsp    (slot_rsp),
        .ow_pull_low (ow_pull_low)
    );

endmodule

//--- hw/ow_regs_pkg.sv
package ow_regs_pkg;

    localparam logic [3:0] ADDR_CONTROL = 4'h0;
    localparam logic [3:0] ADDR_STATUS  = 4'h4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        OP_NONE       = 2'd0,
        OP_RESET      = 2'd1,
        OP_WRITE_BYTE = 2'd2,
        OP_READ_BYTE  = 2'd3
    } ow_op_e;

    // Low bits of CONTROL, op in [9:8] and data in [7:0].
    typedef struct packed {
        ow_op_e     op;
        logic [7:0] data;
    } ow_cmd_t;

    // Low bits of STATUS.
    typedef struct packed {
        logic       busy;
        logic       presence;
        logic [7:0] rx_byte;
    } ow_status_t;

endpackage

//--- hw/ow_slot_timer.sv
`timescale 1ns/1ps

`include "ow_config.svh"

module ow_slot_timer (
    input  logic                  clk,
    input  logic                  reset_flag,
    input  ow_bus_pkg::slot_req_t slot_req,
    input  logic                  ow_in,
    output logic                  slot_ready,
    output ow_bus_pkg::slot_rsp_t slot_rsp,
    output logic                  ow_pull_low
);

    localparam int CPU         = `OW_CLKS_PER_US;
    localparam int RST_END_CYC = (`OW_RESET_LOW_US + `OW_RESET_RECOVER_US) * CPU;
    localparam int TIMER_W     = $clog2(RST_END_CYC + 1);

    // All thresholds are cycles remaining until the end of the slot.
    localparam logic [TIMER_W-1:0] RST_END     = TIMER_W'(RST_END_CYC);
    localparam logic [TIMER_W-1:0] RST_LOW_REM = TIMER_W'(`OW_RESET_RECOVER_US * CPU);
    localparam logic [TIMER_W-1:0] RST_SMP_REM =
        TIMER_W'((`OW_RESET_RECOVER_US - `OW_PRESENCE_SAMPLE_US) * CPU);
    localparam logic [TIMER_W-1:0] SLOT_END    = TIMER_W'(`OW_SLOT_US * CPU);
    localparam logic [TIMER_W-1:0] W1_LOW_REM  =
        TIMER_W'((`OW_SLOT_US - `OW_WRITE1_LOW_US) * CPU);
    localparam logic [TIMER_W-1:0] W0_LOW_REM  =
        TIMER_W'((`OW_SLOT_US - `OW_WRITE0_LOW_US) * CPU);
    localparam logic [TIMER_W-1:0] RD_LOW_REM  =
        TIMER_W'((`OW_SLOT_US - `OW_READ_LOW_US) * CPU);
    localparam logic [TIMER_W-1:0] RD_SMP_REM  =
        TIMER_W'((`OW_SLOT_US - `OW_READ_SAMPLE_US) * CPU);

    logic                   running;
    logic [TIMER_W-1:0]     timer;
    logic [TIMER_W-1:0]     low_rem;
    logic [TIMER_W-1:0]     smp_rem;
    logic                   is_reset;
    logic                   pull_q;
    logic                   done_q;
    logic                   sampled_q;
    logic                   ow_meta;
    logic                   ow_sync;

    assign slot_ready = !running;

    always_ff @(posedge clk) begin
        ow_meta <= ow_in;
        ow_sync <= ow_meta;
    end

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            running <= 1'b0;
            pull_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!running) begin
                if (slot_req.valid) begin
                    running  <= 1'b1;
                    pull_q   <= 1'b1;
                    is_reset <= (slot_req.kind == ow_bus_pkg::SLOT_RESET);
                    case (slot_req.kind)
                        ow_bus_pkg::SLOT_RESET: begin
                            timer   <= RST_END;
                            low_rem <= RST_LOW_REM;
                            smp_rem <= RST_SMP_REM;
                        end
                        ow_bus_pkg::SLOT_WRITE1: begin
                            timer   <= SLOT_END;
                            low_rem <= W1_LOW_REM;
                            smp_rem <= RD_SMP_REM;
                        end
                        ow_bus_pkg::SLOT_WRITE0: begin
                            timer   <= SLOT_END;
                            low_rem <= W0_LOW_REM;
                            smp_rem <= RD_SMP_REM;
                        end
                        default: begin
                            timer   <= SLOT_END;
                            low_rem <= RD_LOW_REM;
                            smp_rem <= RD_SMP_REM;
                        end
                    endcase
                end
            end else begin
                timer <= timer - TIMER_W'(1);
                if (timer == low_rem + TIMER_W'(1)) begin
                    pull_q <= 1'b0; // Release the line, the pull-up takes over.
                end
                if (timer == 1) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    // A slave answers presence by holding the line low.
    always_ff @(posedge clk) begin
        if (running && (timer == smp_rem)) begin
            sampled_q <= is_reset ? !ow_sync : ow_sync;
        end
    end

    assign ow_pull_low = pull_q;
    assign slot_rsp    = '{done: done_q, sampled: sampled_q};

endmodule

//--- project.f
+incdir+hw
hw/ow_bus_pkg.sv
hw/ow_regs_pkg.sv
hw/ow_axil_regs.sv
hw/ow_byte_sequencer.sv
hw/ow_slot_timer.sv
hw/ow_master_top.sv
verif/ow_tb_clock.sv
verif/ow_slave_model.sv
verif/ow_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module ow_tb -f project.f \
    && ./obj_dir/Vow_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "compile or run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

//--- verif/ow_slave_model.sv
`timescale 1ns/1ps

`include "ow_config.svh"

module ow_slave_model (
    input  logic        clk,
    input  logic        reset_flag,
    input  logic        line,
    input  logic        presence_en,
    input  logic        read_en,
    input  logic [7:0]  tx_byte,
    output logic        pull_low,
    output logic        byte_valid,
    output logic [7:0]  byte_out,
    output logic [31:0] slot_count
);

    localparam int CPU          = `OW_CLKS_PER_US;
    localparam int RESET_MIN    = 240 * CPU; // Any longer low is a reset pulse.
    localparam int WRITE1_MAX   = 30 * CPU;
    localparam int PRESENCE_DLY = 15 * CPU;
    localparam int PRESENCE_LEN = 120 * CPU;
    localparam int READ0_LEN    = 30 * CPU;

    logic       line_q;
    logic       in_slot;
    logic       bit_val;
    logic [2:0] bit_idx;
    logic [7:0] rx_shift;
    int         low_cnt;
    int         delay_cnt;
    int         pull_cnt;

    assign bit_val = (low_cnt < WRITE1_MAX);

    always_ff @(posedge clk) begin
        if (reset_flag) begin
            line_q     <= 1'b1;
            in_slot    <= 1'b0;
            bit_idx    <= 3'd0;
            rx_shift   <= 8'd0;
            low_cnt    <= 0;
            delay_cnt  <= 0;
            pull_cnt   <= 0;
            pull_low   <= 1'b0;
            byte_valid <= 1'b0;
            byte_out   <= 8'd0;
            slot_count <= 32'd0;
        end else begin
            line_q     <= line;
            byte_valid <= 1'b0;
            if (in_slot) begin
                low_cnt <= low_cnt + 1;
            end
            if (delay_cnt > 0) begin
                delay_cnt <= delay_cnt - 1;
                if (delay_cnt == 1) begin
                    pull_low <= 1'b1; // Presence pulse starts.
                    pull_cnt <= PRESENCE_LEN;
                end
            end
            if (pull_cnt > 0) begin
                pull_cnt <= pull_cnt - 1;
                if (pull_cnt == 1) begin
                    pull_low <= 1'b0;
                end
            end
            // Only the master can start a slot, the model never pulls a high line.
            if (line_q && !line && !pull_low) begin
                in_slot    <= 1'b1;
                low_cnt    <= 1;
                slot_count <= slot_count + 1;
                if (read_en) begin
                    bit_idx <= bit_idx + 3'd1;
                    if (!tx_byte[bit_idx]) begin
                        pull_low <= 1'b1;
                        pull_cnt <= READ0_LEN;
                    end
                end
            end
            if (!line_q && line && in_slot) begin
                in_slot <= 1'b0;
                if (low_cnt >= RESET_MIN) begin
                    bit_idx <= 3'd0;
                    if (presence_en) begin
                        delay_cnt <= PRESENCE_DLY;
                    end
                end else if (!read_en) begin
                    rx_shift <= {bit_val, rx_shift[7:1]}; // Bits arrive LSB first.
                    bit_idx  <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) begin
                        byte_valid <= 1'b1;
                        byte_out   <= {bit_val, rx_shift[7:1]};
                    end
                end
            end
        end
    end

endmodule

//--- verif/ow_tb.sv
`timescale 1ns/1ps

`include "ow_config.svh"

module ow_tb;

    localparam int     CLK_PERIOD_NS   = 8;
    localparam int     SEED            = 74707;
    localparam int     NUM_BYTES       = 20;
    localparam int     HANDSHAKE_LIMIT = 50;
    localparam int     NUM_OPS         = 2 + 2 * NUM_BYTES + 2;
    localparam longint RESET_CYCLES    =
        longint'(`OW_RESET_LOW_US + `OW_RESET_RECOVER_US) * `OW_CLKS_PER_US;
    localparam longint WATCHDOG_NS     = NUM_OPS * RESET_CYCLES * 2 * CLK_PERIOD_NS;

    logic        clk;
    logic        reset_flag;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;
    logic [1:0]  rresp;
    logic        ow_pull_low;
    logic        ow_line;
    logic        slave_pull;
    logic        presence_en;
    logic        read_en;
    logic [7:0]  tx_byte;
    logic        slave_byte_valid;
    logic [7:0]  slave_byte;
    logic [31:0] slot_count;

    int                   error_count;
    int                   test_errors;
    int                   test_count;
    int                   failed_tests;
    logic [7:0]           rx_bytes[$];
    ow_regs_pkg::ow_cmd_t model_ctrl;

    assign ow_line = !(ow_pull_low || slave_pull); // Open drain with a pull-up.

    ow_tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_i (.clk(clk));

    ow_master_top dut_i (
        .clk         (clk),
        .reset_flag  (reset_flag),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .rresp       (rresp),
        .ow_in       (ow_line),
        .ow_pull_low (ow_pull_low)
    );

    ow_slave_model slave_i (
        .clk         (clk),
        .reset_flag  (reset_flag),
        .line        (ow_line),
        .presence_en (presence_en),
        .read_en     (read_en),
        .tx_byte     (tx_byte),
        .pull_low    (slave_pull),
        .byte_valid  (slave_byte_valid),
        .byte_out    (slave_byte),
        .slot_count  (slot_count)
    );

    always @(negedge clk) begin
        if (slave_byte_valid) begin
            rx_bytes.push_back(slave_byte);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0d ns: %s expected 0x%0h actual 0x%0h",
                 $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0d ns: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: fail, %0d errors", test_count, name,
                     error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // Holds bready low for hold cycles after bvalid rises.
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int waited;
        int i;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        while (!(awready && wready) && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) begin
            report_failure("write address and data handshake timed out");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        for (i = 0; i < hold; i++) begin
            if (!bvalid) begin
                report_failure("bvalid dropped while bready was low");
            end
            @(negedge clk);
        end
        if (!bvalid) begin
            report_failure("write response never arrived");
        end
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int waited;
        int i;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        while (!arready && waited < HANDSHAKE_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) begin
            report_failure("read address handshake timed out");
        end
        @(negedge clk);
        arvalid = 1'b0;
        for (i = 0; i < hold; i++) begin
            if (!rvalid) begin
                report_failure("rvalid dropped while rready was low");
            end
            @(negedge clk);
        end
        if (!rvalid) begin
            report_failure("read response never arrived");
        end
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic read_status(output ow_regs_pkg::ow_status_t st);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(ow_regs_pkg::ADDR_STATUS, 0, data, resp);
        if (resp !== ow_regs_pkg::RESP_OKAY) begin
            report_mismatch("rresp", 32'(ow_regs_pkg::RESP_OKAY), 32'(resp));
        end
        st = ow_regs_pkg::ow_status_t'(data[9:0]);
    endtask

    task automatic wait_idle();
        ow_regs_pkg::ow_status_t st;
        do begin
            repeat (16) @(negedge clk);
            read_status(st);
        end while (st.busy);
    endtask

    task automatic send_cmd(input ow_regs_pkg::ow_op_e op, input logic [7:0] data,
                            input int hold, input logic [1:0] exp_resp);
        ow_regs_pkg::ow_cmd_t cmd;
        logic [1:0]           resp;
        cmd.op   = op;
        cmd.data = data;
        axi_write(ow_regs_pkg::ADDR_CONTROL, {22'd0, cmd}, hold, resp);
        if (resp !== exp_resp) begin
            report_mismatch("bresp", 32'(exp_resp), 32'(resp));
        end
        if (exp_resp == ow_regs_pkg::RESP_OKAY) begin
            model_ctrl = cmd; // CONTROL reads back the last accepted command.
        end
    endtask

    task automatic check_decoded(input logic [7:0] expected);
        if (rx_bytes.size() != 1) begin
            report_failure($sformatf("slave decoded %0d bytes instead of one", rx_bytes.size()));
        end else if (rx_bytes[0] !== expected) begin
            report_mismatch("slave byte", 32'(expected), 32'(rx_bytes[0]));
        end
        rx_bytes.delete();
    endtask

    task automatic reset_state_test();
        ow_regs_pkg::ow_status_t st;
        if (ow_pull_low !== 1'b0) begin
            report_mismatch("ow_pull_low", 32'd0, 32'(ow_pull_low));
        end
        if (bvalid !== 1'b0) begin
            report_mismatch("bvalid", 32'd0, 32'(bvalid));
        end
        if (rvalid !== 1'b0) begin
            report_mismatch("rvalid", 32'd0, 32'(rvalid));
        end
        if (awready !== 1'b0) begin
            report_mismatch("awready", 32'd0, 32'(awready));
        end
        if (wready !== 1'b0) begin
            report_mismatch("wready", 32'd0, 32'(wready));
        end
        if (arready !== 1'b0) begin
            report_mismatch("arready", 32'd0, 32'(arready));
        end
        read_status(st);
        if (st.busy !== 1'b0) begin
            report_mismatch("status.busy", 32'd0, 32'(st.busy));
        end
        finish_test("reset state");
    endtask

    task automatic presence_test();
        ow_regs_pkg::ow_status_t st;
        logic                    first;
        int                      i;
        first = 1'($urandom);
        for (i = 0; i < 2; i++) begin
            presence_en = first ^ i[0];
            send_cmd(ow_regs_pkg::OP_RESET, 8'h00, 0, ow_regs_pkg::RESP_OKAY);
            wait_idle();
            read_status(st);
            if (st.presence !== presence_en) begin
                report_mismatch("status.presence", 32'(presence_en), 32'(st.presence));
            end
        end
        finish_test("reset and presence");
    endtask

    task automatic write_byte_test();
        logic [7:0] b;
        int         i;
        read_en = 1'b0;
        rx_bytes.delete();
        for (i = 0; i < NUM_BYTES; i++) begin
            b = 8'($urandom);
            send_cmd(ow_regs_pkg::OP_WRITE_BYTE, b, 0, ow_regs_pkg::RESP_OKAY);
            wait_idle();
            check_decoded(b);
        end
        finish_test("write byte");
    endtask

    task automatic read_byte_test();
        ow_regs_pkg::ow_status_t st;
        logic [7:0]              b;
        int                      i;
        read_en = 1'b1;
        for (i = 0; i < NUM_BYTES; i++) begin
            b       = 8'($urandom);
            tx_byte = b;
            send_cmd(ow_regs_pkg::OP_READ_BYTE, 8'h00, 0, ow_regs_pkg::RESP_OKAY);
            wait_idle();
            read_status(st);
            if (st.rx_byte !== b) begin
                report_mismatch("status.rx_byte", 32'(b), 32'(st.rx_byte));
            end
        end
        read_en = 1'b0;
        finish_test("read byte");
    endtask

    task automatic error_test();
        logic [31:0] slots;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [7:0]  b;
        rx_bytes.delete();
        slots = slot_count;
        b     = 8'($urandom);
        send_cmd(ow_regs_pkg::OP_WRITE_BYTE, b, 0, ow_regs_pkg::RESP_OKAY);
        send_cmd(ow_regs_pkg::OP_WRITE_BYTE, ~b, 0, ow_regs_pkg::RESP_SLVERR);
        wait_idle();
        check_decoded(b);
        axi_write(4'hC, $urandom, 0, resp);
        if (resp !== ow_regs_pkg::RESP_SLVERR) begin
            report_mismatch("bresp", 32'(ow_regs_pkg::RESP_SLVERR), 32'(resp));
        end
        axi_write(ow_regs_pkg::ADDR_STATUS, $urandom, 0, resp);
        if (resp !== ow_regs_pkg::RESP_SLVERR) begin
            report_mismatch("bresp", 32'(ow_regs_pkg::RESP_SLVERR), 32'(resp));
        end
        axi_read(4'hC, 0, data, resp);
        if (resp !== ow_regs_pkg::RESP_SLVERR) begin
            report_mismatch("rresp", 32'(ow_regs_pkg::RESP_SLVERR), 32'(resp));
        end
        if (data !== 32'd0) begin
            report_mismatch("rdata", 32'd0, data);
        end
        repeat (20) @(negedge clk);
        if (slot_count - slots !== 32'd8) begin
            report_mismatch("slave slot count", 32'd8, slot_count - slots);
        end
        finish_test("error responses");
    endtask

    task automatic backpressure_test();
        ow_regs_pkg::ow_status_t st;
        logic [31:0]             data;
        logic [1:0]              resp;
        logic [7:0]              b;
        int                      hb;
        int                      hr;
        rx_bytes.delete();
        b  = 8'($urandom);
        hb = int'($urandom % 16) + 1;
        hr = int'($urandom % 16) + 1;
        send_cmd(ow_regs_pkg::OP_WRITE_BYTE, b, hb, ow_regs_pkg::RESP_OKAY);
        axi_read(ow_regs_pkg::ADDR_STATUS, hr, data, resp);
        st = ow_regs_pkg::ow_status_t'(data[9:0]);
        if (resp !== ow_regs_pkg::RESP_OKAY) begin
            report_mismatch("rresp", 32'(ow_regs_pkg::RESP_OKAY), 32'(resp));
        end
        if (st.busy !== 1'b1) begin
            report_mismatch("status.busy", 32'd1, 32'(st.busy));
        end
        wait_idle();
        check_decoded(b);
        axi_read(ow_regs_pkg::ADDR_CONTROL, hr, data, resp);
        if (resp !== ow_regs_pkg::RESP_OKAY) begin
            report_mismatch("rresp", 32'(ow_regs_pkg::RESP_OKAY), 32'(resp));
        end
        if (data !== {22'd0, model_ctrl}) begin
            report_mismatch("rdata", {22'd0, model_ctrl}, data);
        end
        finish_test("back-pressure");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset_flag   = 1'b1;
        awaddr       = 4'd0;
        awvalid      = 1'b0;
        wdata        = 32'd0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = 4'd0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        presence_en  = 1'b0;
        read_en      = 1'b0;
        tx_byte      = 8'd0;
        error_count  = 0;
        test_errors  = 0;
        test_count   = 0;
        failed_tests = 0;
        model_ctrl   = '0;
        void'($urandom(SEED));
        repeat (8) @(negedge clk);
        reset_flag = 1'b0;
        @(negedge clk);

        reset_state_test();
        presence_test();
        write_byte_test();
        read_byte_test();
        error_test();
        backpressure_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verif/ow_tb_clock.sv
`timescale 1ns/1ps

module ow_tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule
